// File: rtl/feature_map_ram.sv
`default_nettype none

module feature_map_ram (
	input wire logic clk,
	input wire logic rst,
	input wire logic load_valid,
	input wire pool_pkg::channel_bus_t load_data,
	input wire pool_pkg::coord_t read_row,
	input wire pool_pkg::coord_t read_col,
	output pool_pkg::channel_bus_t pixel_data,
	output logic pixel_store_done
);
	import pool_pkg::*;

	channel_bus_t pixel_mem [PIXEL_COUNT];
	logic [ADDR_WIDTH-1:0] write_addr;
	logic [ADDR_WIDTH-1:0] read_addr;
	logic last_write;

	assign last_write = load_valid && (write_addr == ADDR_WIDTH'(PIXEL_COUNT - 1));

	always_ff @(posedge clk)
	begin
		if (load_valid)
		begin
			pixel_mem[write_addr] <= load_data;
		end
	end

	// raster write address, wraps after the last pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			write_addr <= '0;
			pixel_store_done <= 1'b0;
		end
		else
		begin
			pixel_store_done <= last_write;
			if (last_write)
			begin
				write_addr <= '0;
			end
			else if (load_valid)
			begin
				write_addr <= write_addr + 1'b1;
			end
		end
	end

	assign read_addr = ADDR_WIDTH'(read_row) * ADDR_WIDTH'(LAYER_WIDTH) + ADDR_WIDTH'(read_col);
	assign pixel_data = pixel_mem[read_addr];

endmodule

`default_nettype wire

// File: rtl/layer3_maxpool.sv
`default_nettype none

module layer3_maxpool (
	input wire logic clk,
	input wire logic rst,
	input wire logic pixel_store_done,
	input wire pool_pkg::channel_bus_t pixel_data,
	output pool_pkg::coord_t read_row,
	output pool_pkg::coord_t read_col,
	output logic save_enable,
	output pool_pkg::coord_t output_row,
	output pool_pkg::coord_t output_col,
	output pool_pkg::channel_bus_t output_data,
	output logic pool_done
);
	import pool_pkg::*;

	pool_state_t state;
	pool_state_t next_state;

	logic col_clear;
	logic row_clear;
	logic row_keep;
	logic col_at_end;
	logic row_at_end;

	// window taps, bottom row is the row being read
	channel_bus_t tap_top_left;
	channel_bus_t tap_top_right;
	channel_bus_t tap_bottom_left;
	channel_bus_t tap_bottom_right;
	channel_bus_t line_out;

	// coordinates of tap_bottom_right
	coord_t tap_row;
	coord_t tap_col;

	////////////////////////////////////////
	// sequencer
	////////////////////////////////////////

	assign col_at_end = (read_col == LAST_INDEX);
	assign row_at_end = (read_row == LAST_INDEX);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= POOL_IDLE;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = state;
		col_clear = col_at_end;
		row_clear = col_at_end && row_at_end;
		row_keep = !col_at_end;
		case (state)
			POOL_IDLE:
			begin
				col_clear = 1'b1;
				row_clear = 1'b1;
				if (pixel_store_done)
				begin
					next_state = POOL_FILL;
				end
			end
			// row 0 has no complete window
			POOL_FILL:
			begin
				if (col_at_end)
				begin
					next_state = POOL_SAVE;
				end
			end
			POOL_SAVE:
			begin
				if (pool_done)
				begin
					next_state = POOL_IDLE;
				end
			end
			default:
			begin
				next_state = POOL_IDLE;
			end
		endcase
	end

	step_counter read_col_counter (
		.clk(clk),
		.rst(rst),
		.clear(col_clear),
		.keep(1'b0),
		.count(read_col)
	);

	step_counter read_row_counter (
		.clk(clk),
		.rst(rst),
		.clear(row_clear),
		.keep(row_keep),
		.count(read_row)
	);

	////////////////////////////////////////
	// window
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tap_bottom_right <= '0;
			tap_bottom_left <= '0;
			tap_top_right <= '0;
			tap_top_left <= '0;
			tap_row <= '0;
			tap_col <= '0;
		end
		else
		begin
			tap_bottom_right <= pixel_data;
			tap_bottom_left <= tap_bottom_right;
			tap_top_right <= line_out;
			tap_top_left <= tap_top_right;
			tap_row <= read_row;
			tap_col <= read_col;
		end
	end

	// two taps plus the delay span one row
	line_delay #(
		.DEPTH(LAYER_WIDTH - 2)
	) row_delay (
		.clk(clk),
		.rst(rst),
		.data_in(tap_bottom_left),
		.data_out(line_out)
	);

	window_max pool_max (
		.top_left(tap_top_left),
		.top_right(tap_top_right),
		.bottom_left(tap_bottom_left),
		.bottom_right(tap_bottom_right),
		.max_out(output_data)
	);

	// odd row and odd column close a 2x2 block
	assign save_enable = (state == POOL_SAVE) && tap_row[0] && tap_col[0];
	assign pool_done = save_enable && (tap_row == LAST_INDEX) && (tap_col == LAST_INDEX);
	assign output_row = tap_row >> 1;
	assign output_col = tap_col >> 1;

endmodule

`default_nettype wire

// File: rtl/line_delay.sv
`default_nettype none

module line_delay #(
	parameter int DEPTH = 6
) (
	input wire logic clk,
	input wire logic rst,
	input wire pool_pkg::channel_bus_t data_in,
	output pool_pkg::channel_bus_t data_out
);
	import pool_pkg::*;

	channel_bus_t stages [DEPTH];

	// one stage per cycle of delay
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				stages[i] <= '0;
			end
		end
		else
		begin
			stages[0] <= data_in;
			for (int i = 1; i < DEPTH; i++)
			begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign data_out = stages[DEPTH-1];

endmodule

`default_nettype wire

// File: rtl/pool_pkg.sv
`default_nettype none

package pool_pkg;

	////////////////////////////////////////
	// map geometry
	////////////////////////////////////////

	// input map side
	localparam int LAYER_WIDTH = 8;
	// output map side
	localparam int POOL_WIDTH = LAYER_WIDTH / 2;
	localparam int CHANNELS = 4;
	localparam int DATA_WIDTH = 16;

	////////////////////////////////////////
	// counter and state widths
	////////////////////////////////////////

	localparam int COORD_WIDTH = $clog2(LAYER_WIDTH);
	localparam int PIXEL_COUNT = LAYER_WIDTH * LAYER_WIDTH;
	localparam int ADDR_WIDTH = $clog2(PIXEL_COUNT);
	localparam int STATE_WIDTH = 2;

	typedef logic signed [DATA_WIDTH-1:0] pixel_t;
	// channel k sits in slice k
	typedef pixel_t [CHANNELS-1:0] channel_bus_t;
	typedef logic [COORD_WIDTH-1:0] coord_t;

	localparam coord_t LAST_INDEX = coord_t'(LAYER_WIDTH - 1);

	typedef enum logic [STATE_WIDTH-1:0] {
		POOL_IDLE,
		POOL_FILL,
		POOL_SAVE
	} pool_state_t;

endpackage

`default_nettype wire

// File: rtl/pool_top.sv
`default_nettype none

module pool_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic load_valid,
	input wire pool_pkg::channel_bus_t load_data,
	output logic save_enable,
	output pool_pkg::coord_t output_row,
	output pool_pkg::coord_t output_col,
	output pool_pkg::channel_bus_t output_data,
	output logic pool_done
);
	import pool_pkg::*;

	coord_t read_row;
	coord_t read_col;
	channel_bus_t pixel_data;
	logic pixel_store_done;

	// pixel store
	feature_map_ram map_ram (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_data(load_data),
		.read_row(read_row),
		.read_col(read_col),
		.pixel_data(pixel_data),
		.pixel_store_done(pixel_store_done)
	);

	// starts itself on pixel_store_done
	layer3_maxpool pool_layer (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.pixel_data(pixel_data),
		.read_row(read_row),
		.read_col(read_col),
		.save_enable(save_enable),
		.output_row(output_row),
		.output_col(output_col),
		.output_data(output_data),
		.pool_done(pool_done)
	);

endmodule

`default_nettype wire

// File: rtl/step_counter.sv
`default_nettype none

module step_counter (
	input wire logic clk,
	input wire logic rst,
	input wire logic clear,
	input wire logic keep,
	output pool_pkg::coord_t count
);

	// clear wins over keep
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;
		end
		else if (!keep)
		begin
			count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/window_max.sv
`default_nettype none

module window_max (
	input wire pool_pkg::channel_bus_t top_left,
	input wire pool_pkg::channel_bus_t top_right,
	input wire pool_pkg::channel_bus_t bottom_left,
	input wire pool_pkg::channel_bus_t bottom_right,
	output pool_pkg::channel_bus_t max_out
);
	import pool_pkg::*;

	// winners of the row pairs
	channel_bus_t top_max;
	channel_bus_t bottom_max;

	always_comb
	begin
		for (int k = 0; k < CHANNELS; k++)
		begin
			// signed compare, elements keep pixel_t
			if (top_left[k] > top_right[k])
			begin
				top_max[k] = top_left[k];
			end
			else
			begin
				top_max[k] = top_right[k];
			end
			if (bottom_left[k] > bottom_right[k])
			begin
				bottom_max[k] = bottom_left[k];
			end
			else
			begin
				bottom_max[k] = bottom_right[k];
			end
			if (top_max[k] > bottom_max[k])
			begin
				max_out[k] = top_max[k];
			end
			else
			begin
				max_out[k] = bottom_max[k];
			end
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
verilator --binary --timing -f sources.f --top-module pool_tb -o pool_sim \
	&& ./obj_dir/pool_sim | grep "Verification passed" \
	&& echo "run ok" \
	|| { echo "run not ok"; exit 1; }

// File: sim/pool_tb.sv
`default_nettype none

module pool_tb;
	import pool_pkg::*;

	localparam int POOL_COUNT = POOL_WIDTH * POOL_WIDTH;
	localparam int NUM_CASES = 6;
	localparam logic [31:0] SEED = 32'd57272;
	localparam int PASS_TIMEOUT = 4 * PIXEL_COUNT;
	// ticks counted with the store-done cycle as one
	localparam int FIRST_SAVE_TICK = LAYER_WIDTH + 4;
	localparam int DONE_TICK = PIXEL_COUNT + 2;

	typedef enum int {FILL_RANDOM, FILL_NEGATIVE, FILL_ASCENDING, FILL_CORNER} fill_kind_t;

	logic clk;
	logic rst;
	logic load_valid;
	channel_bus_t load_data;
	logic save_enable;
	coord_t output_row;
	coord_t output_col;
	channel_bus_t output_data;
	logic pool_done;

	fill_kind_t case_fill [NUM_CASES];
	int case_seed [NUM_CASES];
	channel_bus_t map_mem [PIXEL_COUNT];
	channel_bus_t expected_map [POOL_COUNT];
	logic [31:0] rng_state;
	logic timed_out;
	int error_count;
	int check_total;

	pool_top dut_i (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_data(load_data),
		.save_enable(save_enable),
		.output_row(output_row),
		.output_col(output_col),
		.output_data(output_data),
		.pool_done(pool_done)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_flag(input logic got, input logic exp, input string what);
		check_total++;
		if (got !== exp)
		begin
			error_count++;
			$display("[FAIL] t=%0t %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_coord(input coord_t got, input coord_t exp, input string what);
		check_total++;
		if (got !== exp)
		begin
			error_count++;
			$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bus(input channel_bus_t got, input channel_bus_t exp, input string what);
		check_total++;
		if (got !== exp)
		begin
			error_count++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		check_total++;
		if (got != exp)
		begin
			error_count++;
			$display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// stimulus and model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic build_map(input fill_kind_t kind, input int offset);
		logic [31:0] rnd;
		pixel_t value;
		int pick;
		int pos;
		rng_state = SEED + 32'(offset);
		for (int n = 0; n < PIXEL_COUNT; n++)
		begin
			for (int k = 0; k < CHANNELS; k++)
			begin
				rnd = next_random();
				// block corner that holds the peak of this channel
				pick = ((n / LAYER_WIDTH / 2) * POOL_WIDTH + (n % LAYER_WIDTH) / 2
					+ k + offset) % 4;
				pos = ((n / LAYER_WIDTH) % 2) * 2 + (n % LAYER_WIDTH) % 2;
				case (kind)
					FILL_RANDOM: value = pixel_t'(rnd[15:0]);
					FILL_NEGATIVE: value = pixel_t'({1'b1, rnd[14:0]});
					FILL_ASCENDING: value = pixel_t'(n * CHANNELS + k + offset * 97 - 2000);
					default:
					begin
						if (pos == pick)
						begin
							value = pixel_t'(16'h4000 + n * CHANNELS + k);
						end
						else
						begin
							value = pixel_t'({1'b1, rnd[14:0]});
						end
					end
				endcase
				map_mem[n][k] = value;
			end
		end
	endtask

	task automatic build_expected();
		pixel_t best;
		pixel_t cand;
		int base;
		for (int p = 0; p < POOL_COUNT; p++)
		begin
			base = (p / POOL_WIDTH) * 2 * LAYER_WIDTH + (p % POOL_WIDTH) * 2;
			for (int k = 0; k < CHANNELS; k++)
			begin
				best = map_mem[base][k];
				for (int j = 1; j < 4; j++)
				begin
					cand = map_mem[base + (j / 2) * LAYER_WIDTH + (j % 2)][k];
					if (cand > best)
					begin
						best = cand;
					end
				end
				expected_map[p][k] = best;
			end
		end
	endtask

	// one pixel per cycle, outputs must stay quiet
	task automatic load_map();
		for (int n = 0; n < PIXEL_COUNT; n++)
		begin
			@(posedge clk);
			#1;
			load_valid = 1'b1;
			load_data = map_mem[n];
			@(negedge clk);
			check_flag(save_enable, 1'b0, "save_enable while loading");
			check_flag(pool_done, 1'b0, "pool_done while loading");
		end
		@(posedge clk);
		#1;
		load_valid = 1'b0;
		load_data = '0;
	endtask

	task automatic run_pass(input int case_index, output logic timeout_hit);
		int ticks;
		int saves;
		int last_save_tick;
		logic finished;
		ticks = 0;
		saves = 0;
		last_save_tick = 0;
		finished = 1'b0;
		while (!finished && ticks < PASS_TIMEOUT)
		begin
			@(negedge clk);
			ticks++;
			if (save_enable)
			begin
				if (saves == 0)
				begin
					check_count(ticks, FIRST_SAVE_TICK, "first save tick");
				end
				else if (saves % POOL_WIDTH != 0)
				begin
					check_count(ticks - last_save_tick, 2, "save spacing");
				end
				if (saves < POOL_COUNT)
				begin
					check_coord(output_row, coord_t'(saves / POOL_WIDTH), "output_row");
					check_coord(output_col, coord_t'(saves % POOL_WIDTH), "output_col");
					check_bus(output_data, expected_map[saves], "output_data");
				end
				saves++;
				last_save_tick = ticks;
			end
			if (pool_done)
			begin
				check_flag(save_enable, 1'b1, "save_enable with pool_done");
				check_count(saves, POOL_COUNT, "saves per pass");
				check_count(ticks, DONE_TICK, "pool_done tick");
				finished = 1'b1;
			end
		end
		timeout_hit = !finished;
		if (!finished)
		begin
			$display("timeout: case %0d saw no pool_done within %0d cycles", case_index,
				PASS_TIMEOUT);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		load_valid = 1'b0;
		load_data = '0;
		timed_out = 1'b0;
		error_count = 0;
		check_total = 0;
		case_fill = '{FILL_RANDOM, FILL_NEGATIVE, FILL_ASCENDING, FILL_CORNER, FILL_RANDOM,
			FILL_CORNER};
		case_seed = '{0, 1, 0, 2, 3, 5};

		repeat (4)
		begin
			@(negedge clk);
			check_flag(save_enable, 1'b0, "save_enable in reset");
			check_flag(pool_done, 1'b0, "pool_done in reset");
		end
		@(posedge clk);
		#1;
		rst = 1'b0;

		// passes back to back, no reset in between
		for (int i = 0; i < NUM_CASES && !timed_out; i++)
		begin
			build_map(case_fill[i], case_seed[i]);
			build_expected();
			load_map();
			run_pass(i, timed_out);
		end

		if (!timed_out)
		begin
			for (int t = 0; t < 2 * LAYER_WIDTH; t++)
			begin
				@(negedge clk);
				check_flag(save_enable, 1'b0, "save_enable when idle");
				check_flag(pool_done, 1'b0, "pool_done when idle");
			end
		end

		$display("checks %0d, errors %0d", check_total, error_count);
		if (timed_out || error_count != 0)
		begin
			$display("Verification failed");
		end
		else
		begin
			$display("Verification passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/pool_pkg.sv
rtl/step_counter.sv
rtl/line_delay.sv
rtl/window_max.sv
rtl/feature_map_ram.sv
rtl/layer3_maxpool.sv
rtl/pool_top.sv
sim/pool_tb.sv
